//--- include/svreal_align.svh
// move a significand from exponent e to exponent t
// sig holds the value sign-extended to 2*WIDTH bits, sig_width is how many of them matter
// left shifts drop high bits, right shifts keep the sign
function automatic logic signed [WIDTH-1:0] align_sig(
    input logic signed [2*WIDTH-1:0] sig,
    input int                        sig_width,
    input exp_t                      e,
    input exp_t                      t
);
    int                        diff;
    logic signed [2*WIDTH-1:0] shifted;
    diff = int'(e) - int'(t);
    if (diff >= 0) begin
        if (diff >= sig_width) begin
            shifted = '0;
        end else begin
            shifted = sig <<< diff;
        end
    end else begin
        if (-diff >= sig_width) begin
            shifted = {(2*WIDTH){sig[2*WIDTH-1]}};
        end else begin
            shifted = sig >>> (-diff);
        end
    end
    // wrap to the result width
    return shifted[WIDTH-1:0];
endfunction

//--- logic/svreal_pkg.sv
package svreal_pkg;

    // every exponent in the design uses this width
    localparam int EXP_WIDTH = 16;

    typedef logic signed [EXP_WIDTH-1:0] exp_t;

    // request opcodes
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_MUL    = 4'd2,
        OP_MIN    = 4'd3,
        OP_MAX    = 4'd4,
        OP_GT     = 4'd5,
        OP_GE     = 4'd6,
        OP_LT     = 4'd7,
        OP_LE     = 4'd8,
        OP_EQ     = 4'd9,
        OP_NE     = 4'd10,
        OP_TO_INT = 4'd11
    } sv_opcode_e;

    // four-phase handshake controller states
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_CALC     = 2'd1,
        ST_ACK      = 2'd2,
        ST_WAIT_LOW = 2'd3
    } ctrl_state_e;

endpackage

//--- logic/svreal_addsub.sv
`timescale 1ns/1ps

module svreal_addsub
    import svreal_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic                    sub_i,
    input  logic signed [WIDTH-1:0] a_sig_i,
    input  exp_t                    a_exp_i,
    input  logic signed [WIDTH-1:0] b_sig_i,
    input  exp_t                    b_exp_i,
    input  exp_t                    res_exp_i,
    output logic signed [WIDTH-1:0] sum_o
);

    `include "svreal_align.svh"

    logic signed [WIDTH-1:0] a_aligned;
    logic signed [WIDTH-1:0] b_aligned;

    // both operands go straight to the result format
    assign a_aligned = align_sig((2*WIDTH)'(a_sig_i), WIDTH, a_exp_i, res_exp_i);
    assign b_aligned = align_sig((2*WIDTH)'(b_sig_i), WIDTH, b_exp_i, res_exp_i);

    // wraps at WIDTH bits, no saturation
    always_comb begin
        if (sub_i) begin
            sum_o = a_aligned - b_aligned;
        end else begin
            sum_o = a_aligned + b_aligned;
        end
    end

endmodule

//--- logic/svreal_mul.sv
`timescale 1ns/1ps

module svreal_mul
    import svreal_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic signed [WIDTH-1:0] a_sig_i,
    input  exp_t                    a_exp_i,
    input  logic signed [WIDTH-1:0] b_sig_i,
    input  exp_t                    b_exp_i,
    input  exp_t                    res_exp_i,
    output logic signed [WIDTH-1:0] prod_o
);

    `include "svreal_align.svh"

    logic signed [2*WIDTH-1:0] full_prod;
    exp_t                      prod_exp;

    // full product never overflows 2*WIDTH bits
    assign full_prod = (2*WIDTH)'(a_sig_i) * (2*WIDTH)'(b_sig_i);

    // exponents add under multiplication
    assign prod_exp = a_exp_i + b_exp_i;

    // realign the wide product and keep the low WIDTH bits
    assign prod_o = align_sig(full_prod, 2*WIDTH, prod_exp, res_exp_i);

endmodule

//--- logic/svreal_compare.sv
`timescale 1ns/1ps

module svreal_compare
    import svreal_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  sv_opcode_e              opcode_i,
    input  logic signed [WIDTH-1:0] a_sig_i,
    input  exp_t                    a_exp_i,
    input  logic signed [WIDTH-1:0] b_sig_i,
    input  exp_t                    b_exp_i,
    input  exp_t                    res_exp_i,
    output logic                    flag_o,
    output logic signed [WIDTH-1:0] pick_o
);

    `include "svreal_align.svh"

    exp_t                    max_exp;
    int                      exp_spread;
    logic signed [WIDTH-1:0] a_aligned;
    logic signed [WIDTH-1:0] b_aligned;
    logic                    pick_b;

    // compare at the coarser of the two exponents
    assign max_exp    = (a_exp_i >= b_exp_i) ? a_exp_i : b_exp_i;
    assign exp_spread = (a_exp_i >= b_exp_i) ? int'(a_exp_i) - int'(b_exp_i)
                                             : int'(b_exp_i) - int'(a_exp_i);

    assign a_aligned = align_sig((2*WIDTH)'(a_sig_i), WIDTH, a_exp_i, max_exp);
    assign b_aligned = align_sig((2*WIDTH)'(b_sig_i), WIDTH, b_exp_i, max_exp);

    always_comb begin
        case (opcode_i)
            OP_GT:   flag_o = (a_aligned > b_aligned);
            OP_GE:   flag_o = (a_aligned >= b_aligned);
            OP_LT:   flag_o = (a_aligned < b_aligned);
            OP_LE:   flag_o = (a_aligned <= b_aligned);
            OP_EQ:   flag_o = (a_aligned == b_aligned);
            OP_NE:   flag_o = (a_aligned != b_aligned);
            default: flag_o = 1'b0;
        endcase
    end

    // strict test, so ties keep a
    assign pick_b = (opcode_i == OP_MAX) ? (b_aligned > a_aligned) : (b_aligned < a_aligned);

    // chosen operand leaves in the result format
    always_comb begin
        if (pick_b) begin
            pick_o = align_sig((2*WIDTH)'(b_sig_i), WIDTH, b_exp_i, res_exp_i);
        end else begin
            pick_o = align_sig((2*WIDTH)'(a_sig_i), WIDTH, a_exp_i, res_exp_i);
        end
    end

    // a wider spread shifts the smaller operand entirely out
    always_comb begin
        if (!$isunknown({a_exp_i, b_exp_i})) begin
            assert (exp_spread <= WIDTH)
                else $error("compare alignment shift %0d exceeds %0d bits", exp_spread, WIDTH);
        end
    end

endmodule

//--- logic/svreal_op_unit.sv
`timescale 1ns/1ps

module svreal_op_unit
    import svreal_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_i,
    input  sv_opcode_e              opcode_i,
    input  logic signed [WIDTH-1:0] a_sig_i,
    input  exp_t                    a_exp_i,
    input  logic signed [WIDTH-1:0] b_sig_i,
    input  exp_t                    b_exp_i,
    input  exp_t                    res_exp_i,
    output logic signed [WIDTH-1:0] result_sig_o,
    output exp_t                    result_exp_o,
    output logic                    flag_o
);

    `include "svreal_align.svh"

    logic signed [WIDTH-1:0] sum;
    logic signed [WIDTH-1:0] prod;
    logic signed [WIDTH-1:0] pick;
    logic signed [WIDTH-1:0] int_val;
    logic                    cmp_flag;
    logic signed [WIDTH-1:0] next_sig;
    exp_t                    next_exp;
    logic                    next_flag;

    svreal_addsub #(
        .WIDTH(WIDTH)
    ) addsub_i (
        .sub_i    (opcode_i == OP_SUB),
        .a_sig_i  (a_sig_i),
        .a_exp_i  (a_exp_i),
        .b_sig_i  (b_sig_i),
        .b_exp_i  (b_exp_i),
        .res_exp_i(res_exp_i),
        .sum_o    (sum)
    );

    svreal_mul #(
        .WIDTH(WIDTH)
    ) mul_i (
        .a_sig_i  (a_sig_i),
        .a_exp_i  (a_exp_i),
        .b_sig_i  (b_sig_i),
        .b_exp_i  (b_exp_i),
        .res_exp_i(res_exp_i),
        .prod_o   (prod)
    );

    svreal_compare #(
        .WIDTH(WIDTH)
    ) compare_i (
        .opcode_i (opcode_i),
        .a_sig_i  (a_sig_i),
        .a_exp_i  (a_exp_i),
        .b_sig_i  (b_sig_i),
        .b_exp_i  (b_exp_i),
        .res_exp_i(res_exp_i),
        .flag_o   (cmp_flag),
        .pick_o   (pick)
    );

    // integer conversion is a at exponent zero
    assign int_val = align_sig((2*WIDTH)'(a_sig_i), WIDTH, a_exp_i, exp_t'(0));

    always_comb begin
        next_sig  = '0;
        next_exp  = res_exp_i;
        next_flag = 1'b0;
        case (opcode_i)
            OP_ADD, OP_SUB: next_sig = sum;
            OP_MUL:         next_sig = prod;
            OP_MIN, OP_MAX: next_sig = pick;
            OP_GT, OP_GE, OP_LT, OP_LE, OP_EQ, OP_NE: next_flag = cmp_flag;
            OP_TO_INT: begin
                next_sig = int_val;
                next_exp = '0;
            end
            default: next_sig = '0;
        endcase
    end

    // result register, held between requests
    always_ff @(posedge clk) begin
        if (rst) begin
            result_sig_o <= '0;
            result_exp_o <= '0;
            flag_o       <= 1'b0;
        end else if (load_i) begin
            result_sig_o <= next_sig;
            result_exp_o <= next_exp;
            flag_o       <= next_flag;
        end
    end

    // captured opcode must be a real operation by the time it is used
    assert property (@(posedge clk) disable iff (rst)
        load_i |-> opcode_i inside {OP_ADD, OP_SUB, OP_MUL, OP_MIN, OP_MAX, OP_GT, OP_GE,
                                    OP_LT, OP_LE, OP_EQ, OP_NE, OP_TO_INT})
        else $error("undefined opcode %0d at result load", opcode_i);

endmodule

//--- logic/svreal_req_ctrl.sv
`timescale 1ns/1ps

module svreal_req_ctrl
    import svreal_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_i,
    input  sv_opcode_e              opcode_i,
    input  logic signed [WIDTH-1:0] a_sig_i,
    input  exp_t                    a_exp_i,
    input  logic signed [WIDTH-1:0] b_sig_i,
    input  exp_t                    b_exp_i,
    input  exp_t                    res_exp_i,
    output logic                    ack_o,
    output logic                    load_o,
    output sv_opcode_e              op_code_o,
    output logic signed [WIDTH-1:0] op_a_sig_o,
    output exp_t                    op_a_exp_o,
    output logic signed [WIDTH-1:0] op_b_sig_o,
    output exp_t                    op_b_exp_o,
    output exp_t                    op_res_exp_o
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        accept;

    // new request only taken from idle
    assign accept = (state == ST_IDLE) && req_i;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req_i) begin
                    state_nxt = ST_CALC;
                end
            end
            ST_CALC: state_nxt = ST_ACK;
            ST_ACK: begin
                // hold here while the requester keeps req high
                if (!req_i) begin
                    state_nxt = ST_WAIT_LOW;
                end
            end
            ST_WAIT_LOW: state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    // ack lags the state by one edge, so it rises at edge 2 and drops after wait_low
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            ack_o <= 1'b0;
        end else begin
            state <= state_nxt;
            ack_o <= (state == ST_ACK);
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if (accept) begin
            op_code_o    <= opcode_i;
            op_a_sig_o   <= a_sig_i;
            op_a_exp_o   <= a_exp_i;
            op_b_sig_o   <= b_sig_i;
            op_b_exp_o   <= b_exp_i;
            op_res_exp_o <= res_exp_i;
        end
    end

    assign load_o = (state == ST_CALC);

    assert property (@(posedge clk) disable iff (rst) $rose(ack_o) |-> req_i)
        else $error("ack raised with no request pending");

    assert property (@(posedge clk) disable iff (rst) load_o |=> !load_o)
        else $error("result load strobe longer than one cycle");

endmodule

//--- logic/svreal_alu_top.sv
`timescale 1ns/1ps

module svreal_alu_top
    import svreal_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_i,
    input  sv_opcode_e              opcode_i,
    input  logic signed [WIDTH-1:0] a_sig_i,
    input  exp_t                    a_exp_i,
    input  logic signed [WIDTH-1:0] b_sig_i,
    input  exp_t                    b_exp_i,
    input  exp_t                    res_exp_i,
    output logic                    ack_o,
    output logic signed [WIDTH-1:0] result_sig_o,
    output exp_t                    result_exp_o,
    output logic                    flag_o
);

    // captured request
    logic                    load_result;
    sv_opcode_e              op_code;
    logic signed [WIDTH-1:0] op_a_sig;
    exp_t                    op_a_exp;
    logic signed [WIDTH-1:0] op_b_sig;
    exp_t                    op_b_exp;
    exp_t                    op_res_exp;

    svreal_req_ctrl #(
        .WIDTH(WIDTH)
    ) req_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .opcode_i    (opcode_i),
        .a_sig_i     (a_sig_i),
        .a_exp_i     (a_exp_i),
        .b_sig_i     (b_sig_i),
        .b_exp_i     (b_exp_i),
        .res_exp_i   (res_exp_i),
        .ack_o       (ack_o),
        .load_o      (load_result),
        .op_code_o   (op_code),
        .op_a_sig_o  (op_a_sig),
        .op_a_exp_o  (op_a_exp),
        .op_b_sig_o  (op_b_sig),
        .op_b_exp_o  (op_b_exp),
        .op_res_exp_o(op_res_exp)
    );

    svreal_op_unit #(
        .WIDTH(WIDTH)
    ) op_unit_i (
        .clk         (clk),
        .rst         (rst),
        .load_i      (load_result),
        .opcode_i    (op_code),
        .a_sig_i     (op_a_sig),
        .a_exp_i     (op_a_exp),
        .b_sig_i     (op_b_sig),
        .b_exp_i     (op_b_exp),
        .res_exp_i   (op_res_exp),
        .result_sig_o(result_sig_o),
        .result_exp_o(result_exp_o),
        .flag_o      (flag_o)
    );

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // reset released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- verif/svreal_alu_tb.sv
`timescale 1ns/1ps

module svreal_alu_tb
    import svreal_pkg::*;
();

    localparam int WIDTH        = 16;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int N_ARITH      = 200;
    localparam int N_CMP        = 200;
    localparam int N_MINMAX     = 150;
    localparam int N_BP         = 50;
    localparam int TOTAL_TXN    = 1 + N_ARITH + N_CMP + N_MINMAX + N_BP;
    localparam int ACK_WAIT_MAX = 16;
    // ten cycles per transaction plus the reset phase
    localparam int WATCHDOG_NS  = TOTAL_TXN * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic                    clk;
    logic                    rst;
    logic                    req_i;
    sv_opcode_e              opcode_i;
    logic signed [WIDTH-1:0] a_sig_i;
    exp_t                    a_exp_i;
    logic signed [WIDTH-1:0] b_sig_i;
    exp_t                    b_exp_i;
    exp_t                    res_exp_i;
    logic                    ack_o;
    logic signed [WIDTH-1:0] result_sig_o;
    exp_t                    result_exp_o;
    logic                    flag_o;
    int                      checks;
    int                      errors;

    tb_clk_gen #(
        .HALF_PERIOD (CLK_PERIOD / 2),
        .RESET_CYCLES(RESET_CYCLES)
    ) clk_gen_i (
        .clk_o(clk),
        .rst_o(rst)
    );

    svreal_alu_top #(
        .WIDTH(WIDTH)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .opcode_i    (opcode_i),
        .a_sig_i     (a_sig_i),
        .a_exp_i     (a_exp_i),
        .b_sig_i     (b_sig_i),
        .b_exp_i     (b_exp_i),
        .res_exp_i   (res_exp_i),
        .ack_o       (ack_o),
        .result_sig_o(result_sig_o),
        .result_exp_o(result_exp_o),
        .flag_o      (flag_o)
    );

    task automatic check_value(input string name, input longint actual, input longint expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    // reference alignment on 64-bit integers
    function automatic longint model_align(input longint value, input int sig_width,
                                           input int e, input int t);
        int     diff;
        longint r;
        diff = e - t;
        if (diff >= 0) begin
            r = (diff >= sig_width) ? 64'sd0 : (value <<< diff);
        end else if (-diff >= sig_width) begin
            r = (value < 64'sd0) ? -64'sd1 : 64'sd0;
        end else begin
            r = value >>> (-diff);
        end
        return r;
    endfunction

    function automatic logic signed [WIDTH-1:0] wrap_sig(input longint v);
        return v[WIDTH-1:0];
    endfunction

    task automatic predict(input sv_opcode_e op,
                           input logic signed [WIDTH-1:0] a_sig, input exp_t a_exp,
                           input logic signed [WIDTH-1:0] b_sig, input exp_t b_exp,
                           input exp_t res_exp,
                           output logic signed [WIDTH-1:0] exp_sig,
                           output exp_t exp_exp, output logic exp_flag);
        int     top_exp;
        longint a_top;
        longint b_top;
        longint a_res;
        longint b_res;
        top_exp = (int'(a_exp) > int'(b_exp)) ? int'(a_exp) : int'(b_exp);
        a_top = model_align(longint'(a_sig), WIDTH, int'(a_exp), top_exp);
        b_top = model_align(longint'(b_sig), WIDTH, int'(b_exp), top_exp);
        a_res = model_align(longint'(a_sig), WIDTH, int'(a_exp), int'(res_exp));
        b_res = model_align(longint'(b_sig), WIDTH, int'(b_exp), int'(res_exp));
        exp_sig  = '0;
        exp_exp  = res_exp;
        exp_flag = 1'b0;
        case (op)
            OP_ADD: exp_sig = wrap_sig(a_res + b_res);
            OP_SUB: exp_sig = wrap_sig(a_res - b_res);
            OP_MUL: begin
                exp_sig = wrap_sig(model_align(longint'(a_sig) * longint'(b_sig), 2 * WIDTH,
                                               int'(a_exp) + int'(b_exp), int'(res_exp)));
            end
            // ties keep a
            OP_MIN: exp_sig = wrap_sig((b_top < a_top) ? b_res : a_res);
            OP_MAX: exp_sig = wrap_sig((b_top > a_top) ? b_res : a_res);
            OP_GT: exp_flag = (a_top > b_top);
            OP_GE: exp_flag = (a_top >= b_top);
            OP_LT: exp_flag = (a_top < b_top);
            OP_LE: exp_flag = (a_top <= b_top);
            OP_EQ: exp_flag = (a_top == b_top);
            OP_NE: exp_flag = (a_top != b_top);
            OP_TO_INT: begin
                exp_sig = wrap_sig(model_align(longint'(a_sig), WIDTH, int'(a_exp), 0));
                exp_exp = '0;
            end
            default: exp_sig = '0;
        endcase
    endtask

    function automatic exp_t rand_exp();
        int v;
        v = int'($urandom_range(16, 0)) - 8;
        return exp_t'(v);
    endfunction

    function automatic logic signed [WIDTH-1:0] rand_sig();
        return WIDTH'($urandom);
    endfunction

    // opcodes are numbered contiguously inside each group
    function automatic sv_opcode_e rand_op(input sv_opcode_e first, input int count);
        int pick;
        pick = int'(first) + int'($urandom_range(count - 1, 0));
        return sv_opcode_e'(4'(pick));
    endfunction

    // full four-phase transaction, holding req for extra cycles after ack
    task automatic do_txn(input sv_opcode_e op,
                          input logic signed [WIDTH-1:0] a_sig, input exp_t a_exp,
                          input logic signed [WIDTH-1:0] b_sig, input exp_t b_exp,
                          input exp_t res_exp, input int hold,
                          output logic signed [WIDTH-1:0] got_sig,
                          output exp_t got_exp, output logic got_flag);
        int wait_cnt;
        @(posedge clk);
        req_i     <= 1'b1;
        opcode_i  <= op;
        a_sig_i   <= a_sig;
        a_exp_i   <= a_exp;
        b_sig_i   <= b_sig;
        b_exp_i   <= b_exp;
        res_exp_i <= res_exp;
        // edge 0, the first one that sees req high
        @(posedge clk);
        wait_cnt = 0;
        while (!ack_o && wait_cnt < ACK_WAIT_MAX) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!ack_o) begin
            errors++;
            $display("no ack from the DUT within %0d cycles of a request", ACK_WAIT_MAX);
        end else begin
            // ack is seen one edge after the edge that set it
            check_value("ack_o rise latency", longint'(wait_cnt - 1), 64'sd2);
        end
        got_sig  = result_sig_o;
        got_exp  = result_exp_o;
        got_flag = flag_o;
        repeat (hold) begin
            @(posedge clk);
            check_value("ack_o", longint'(ack_o), 64'sd1);
            check_value("result_sig_o held", longint'(result_sig_o), longint'(got_sig));
            check_value("result_exp_o held", longint'(result_exp_o), longint'(got_exp));
            check_value("flag_o held", longint'(flag_o), longint'(got_flag));
        end
        req_i   <= 1'b0;
        // operands are free to change once req is low
        a_sig_i <= rand_sig();
        b_sig_i <= rand_sig();
        a_exp_i <= rand_exp();
        wait_cnt = 0;
        while (ack_o && wait_cnt < ACK_WAIT_MAX) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (ack_o) begin
            errors++;
            $display("ack_o still high %0d cycles after req_i dropped", ACK_WAIT_MAX);
        end else begin
            check_value("ack_o fall latency", longint'(wait_cnt - 2), 64'sd1);
        end
        check_value("result_sig_o after ack", longint'(result_sig_o), longint'(got_sig));
    endtask

    task automatic run_check(input sv_opcode_e op,
                             input logic signed [WIDTH-1:0] a_sig, input exp_t a_exp,
                             input logic signed [WIDTH-1:0] b_sig, input exp_t b_exp,
                             input exp_t res_exp, input int hold);
        logic signed [WIDTH-1:0] got_sig;
        exp_t                    got_exp;
        logic                    got_flag;
        logic signed [WIDTH-1:0] exp_sig;
        exp_t                    exp_exp;
        logic                    exp_flag;
        do_txn(op, a_sig, a_exp, b_sig, b_exp, res_exp, hold, got_sig, got_exp, got_flag);
        predict(op, a_sig, a_exp, b_sig, b_exp, res_exp, exp_sig, exp_exp, exp_flag);
        check_value("result_sig_o", longint'(got_sig), longint'(exp_sig));
        check_value("result_exp_o", longint'(got_exp), longint'(exp_exp));
        check_value("flag_o", longint'(got_flag), longint'(exp_flag));
    endtask

    task automatic report_test(input string name, input int txns, input int err_before);
        $display("test %s: %0d transactions, %0d errors", name, txns, errors - err_before);
    endtask

    // mode 0 arith, 1 compare, 2 min/max/int, 3 any opcode with back-pressure
    task automatic run_random(input string name, input int mode, input int count);
        int                      err_before;
        int                      hold;
        sv_opcode_e              op;
        logic signed [WIDTH-1:0] a_sig;
        logic signed [WIDTH-1:0] b_sig;
        exp_t                    a_exp;
        exp_t                    b_exp;
        exp_t                    res_exp;
        err_before = errors;
        for (int i = 0; i < count; i++) begin
            a_sig   = rand_sig();
            b_sig   = rand_sig();
            a_exp   = rand_exp();
            b_exp   = rand_exp();
            res_exp = rand_exp();
            hold    = 0;
            case (mode)
                0: begin
                    op = rand_op(OP_ADD, 3);
                    // large left shift wraps the result
                    if (i % 4 == 3) begin
                        a_exp   = exp_t'(8);
                        res_exp = exp_t'(-8);
                    end
                end
                1: op = rand_op(OP_GT, 6);
                2: op = ($urandom_range(2, 0) == 0) ? OP_TO_INT : rand_op(OP_MIN, 2);
                default: begin
                    op   = rand_op(OP_ADD, 12);
                    hold = int'($urandom_range(10, 1));
                end
            endcase
            // plant equal operands
            if ((mode == 1 || mode == 2) && i % 4 == 0) begin
                b_sig = a_sig;
                b_exp = a_exp;
            end
            run_check(op, a_sig, a_exp, b_sig, b_exp, res_exp, hold);
        end
        report_test(name, count, err_before);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the req/ack handshake hung", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int err_before;
        void'($urandom(32'hc65d));
        checks    = 0;
        errors    = 0;
        req_i     = 1'b0;
        opcode_i  = OP_ADD;
        a_sig_i   = '0;
        a_exp_i   = '0;
        b_sig_i   = '0;
        b_exp_i   = '0;
        res_exp_i = '0;
        @(posedge clk);
        while (rst) @(posedge clk);

        err_before = errors;
        check_value("ack_o", longint'(ack_o), 64'sd0);
        check_value("result_sig_o", longint'(result_sig_o), 64'sd0);
        check_value("result_exp_o", longint'(result_exp_o), 64'sd0);
        check_value("flag_o", longint'(flag_o), 64'sd0);
        run_check(OP_ADD, 16'sd300, exp_t'(2), -16'sd45, exp_t'(-1), exp_t'(0), 0);
        report_test("reset and handshake timing", 1, err_before);

        run_random("add, sub and mul", 0, N_ARITH);
        run_random("comparisons", 1, N_CMP);
        run_random("min, max and to-int", 2, N_MINMAX);
        run_random("back-pressure", 3, N_BP);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- svreal_alu.f
+incdir+include
logic/svreal_pkg.sv
logic/svreal_addsub.sv
logic/svreal_mul.sv
logic/svreal_compare.sv
logic/svreal_op_unit.sv
logic/svreal_req_ctrl.sv
logic/svreal_alu_top.sv
verif/tb_clk_gen.sv
verif/svreal_alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the svreal_alu testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
log_file="sim.log"

verilator --binary --timing --assert \
    --top-module svreal_alu_tb \
    --Mdir "$build_dir" \
    -f svreal_alu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./${build_dir}/Vsvreal_alu_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$log_file"; then
    echo "no verdict found in ${log_file}"
    exit 1
fi
exit 0
